// ==== flist.f ====
+incdir+rtl
rtl/n163_pkg.sv
rtl/n163_bank_regs.sv
rtl/n163_irq_counter.sv
rtl/n163_cpu_port.sv
rtl/n163_mapper.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/n163_sva.sv
testbench/tb_n163.sv

// ==== rtl/n163_bank_regs.sv ====
// n163 bank register file: cpu writes at $8000-$f7ff, combinational prg and chr bank lookup
`timescale 1ns/1ns
`include "n163_cfg.svh"

module n163_bank_regs (
	input  logic                 clk20,
	input  logic                 reset,
	input  n163_pkg::cpu_bus_t   cpu,
	input  logic [13:0]          chr_addr,
	output n163_pkg::bank_map_t  map
);

	logic [7:0] chr_reg [0:`N163_CHR_REGS-1]; // $8000-$dfff, one per 2k page
	logic [5:0] prg89;
	logic [5:0] prg_ab;
	logic [5:0] prg_cd;
	logic [1:0] chr_en;  // per half of pattern space, 1 keeps chr rom
	logic [1:0] mirror;

	logic [4:0] page;
	logic [5:0] prg_raw;
	logic [5:0] prg_low_mask;
	logic [3:0] chr_sel;
	logic [7:0] chr_raw;
	logic       vram_bank;   // bank bits 17:15 all ones
	logic       pattern_ram;
	logic       fixed_a10;

	assign page = cpu.addr[15:11];

	always_ff @(posedge clk20) begin
		if (reset) begin
			for (int i = 0; i < `N163_CHR_REGS; i++) begin
				chr_reg[i] <= 8'h00;
			end
			prg89  <= 6'd0;
			prg_ab <= 6'd0;
			prg_cd <= 6'd0;
			chr_en <= 2'b00;
			mirror <= `N163_VERTICAL ? 2'b01 : 2'b10;
		end else if (cpu.ce && cpu.write) begin
			case (page)
				`N163_PAGE_CTRL_E000: {mirror, prg89}  <= cpu.wdata;
				`N163_PAGE_CTRL_E800: {chr_en, prg_ab} <= cpu.wdata;
				`N163_PAGE_CTRL_F000: prg_cd <= cpu.wdata[5:0];
				default: begin
					// $8000-$dfff, addr[14:11] picks the slot directly
					if (page[4] && page[3:0] < 4'(`N163_CHR_REGS)) begin
						chr_reg[page[3:0]] <= cpu.wdata;
					end
				end
			endcase
		end
	end

	// prg window select, $e000 window is fixed to the last bank
	always_comb begin
		case (cpu.addr[14:13])
			2'd0: prg_raw = prg89;
			2'd1: prg_raw = prg_ab;
			2'd2: prg_raw = prg_cd;
			default: prg_raw = 6'b111111;
		endcase
	end

	// below $8000 only the 32k block bits survive
	assign prg_low_mask = {4'b1111, {2{cpu.addr[15]}}};

	// nametable space reuses the last four slots
	assign chr_sel = chr_addr[13] ? {2'b10, chr_addr[11:10]} : {1'b0, chr_addr[12:10]};
	assign chr_raw = chr_reg[chr_sel];

	assign vram_bank   = &chr_raw[7:5];
	assign pattern_ram = vram_bank && !(chr_addr[12] ? chr_en[1] : chr_en[0]);

	// board mirroring, only seen while the address is not routed to vram
	always_comb begin
		case (mirror)
			2'b00: fixed_a10 = 1'b0;
			2'b01: fixed_a10 = chr_addr[10]; // vertical
			2'b10: fixed_a10 = chr_addr[11]; // horizontal
			default: fixed_a10 = 1'b1;
		endcase
	end

	always_comb begin
		map.prg_bank = prg_raw & `N163_PRG_MASK & prg_low_mask;
		map.chr_bank = {chr_raw[7:2] & `N163_CHR_MASK, chr_raw[1:0]};
		if (chr_addr[13]) begin
			map.ciram_ce = vram_bank;
		end else begin
			map.ciram_ce = pattern_ram;
		end
		map.vram_a10 = map.ciram_ce ? chr_raw[0] : fixed_a10; // bank bit 10
	end

endmodule

// ==== rtl/n163_cfg.svh ====
// address decode values, bank masks and fixed address bits for the n163 mapper, include where needed
`ifndef N163_CFG_SVH
`define N163_CFG_SVH

// bank masks, all ones keeps the full 512k prg / 256k chr range
`define N163_PRG_MASK 6'b111111
`define N163_CHR_MASK 6'b111111

// mirroring loaded at reset, 1 = vertical
`define N163_VERTICAL 1'b1

// 2k pages of the $4000-$5fff register space (addr[15:11])
`define N163_PAGE_SOUND  5'b01001
`define N163_PAGE_IRQ_LO 5'b01010
`define N163_PAGE_IRQ_HI 5'b01011

// 2k pages of the control registers above the chr bank block
`define N163_PAGE_CTRL_E000 5'b11100
`define N163_PAGE_CTRL_E800 5'b11101
`define N163_PAGE_CTRL_F000 5'b11110

// work ram window $6000-$7fff lands here (prg address bits 21:13)
`define N163_WRAM_BANK 9'b111100000

// chr rom base (chr address bits 21:18)
`define N163_CHR_BASE 4'b1000

// decoded pattern bank count: eight 1k pattern slots plus four nametable slots
`define N163_CHR_REGS 12

`endif

// ==== rtl/n163_cpu_port.sv ====
// n163 cpu side: register read mux, output enable, prg address and memory allow
`timescale 1ns/1ns
`include "n163_cfg.svh"

module n163_cpu_port (
	input  n163_pkg::cpu_bus_t    cpu,
	input  n163_pkg::bank_map_t   map,
	input  n163_pkg::irq_state_t  irq_state,
	output logic [7:0]            prg_dout,
	output logic                  prg_oe,
	output logic [21:0]           prg_aout,
	output logic                  prg_allow
);

	logic [4:0] page;
	logic       read;
	logic       is_wram;   // $6000-$7fff
	logic       is_rom;    // $8000-$ffff
	logic       is_mapper; // $4800-$5fff

	assign page      = cpu.addr[15:11];
	assign read      = !cpu.write;
	assign is_wram   = cpu.addr[15:13] == 3'b011;
	assign is_rom    = cpu.addr[15];
	assign is_mapper = (page == `N163_PAGE_SOUND) || (page == `N163_PAGE_IRQ_LO)
		|| (page == `N163_PAGE_IRQ_HI);

	always_comb begin
		case (page)
			`N163_PAGE_SOUND:  prg_dout = 8'h00; // no sound ram behind this port
			`N163_PAGE_IRQ_LO: prg_dout = irq_state.count[7:0];
			`N163_PAGE_IRQ_HI: prg_dout = irq_state.count[15:8];
			default:           prg_dout = cpu.wdata;
		endcase
	end

	// mapper drives the data bus for its own registers, wram and rom
	assign prg_oe = read && (is_mapper || is_wram || is_rom);

	always_comb begin
		if (is_wram) begin
			prg_aout = {`N163_WRAM_BANK, cpu.addr[12:0]};
		end else begin
			prg_aout = {3'b000, map.prg_bank, cpu.addr[12:0]};
		end
	end

	assign prg_allow = (is_rom && read) || is_wram; // rom is read only

endmodule

// ==== rtl/n163_irq_counter.sv ====
// n163 15-bit cpu cycle counter with saturation irq, loaded and read at $5000/$5800
`timescale 1ns/1ns
`include "n163_cfg.svh"

module n163_irq_counter (
	input  logic                  clk20,
	input  logic                  reset,
	input  n163_pkg::cpu_bus_t    cpu,
	output n163_pkg::irq_state_t  irq_state
);

	logic [15:0] count;
	logic [15:0] count_next;
	logic        irq;
	logic [4:0]  page;
	logic        count_up;
	logic        ack;     // any access to $5000-$5fff
	logic        load_lo;
	logic        load_hi;

	assign page       = cpu.addr[15:11];
	assign count_next = count + 16'd1;
	assign count_up   = count[15] && !(&count[14:0]); // runs until saturated
	assign ack        = (page == `N163_PAGE_IRQ_LO) || (page == `N163_PAGE_IRQ_HI);
	assign load_lo    = cpu.write && (page == `N163_PAGE_IRQ_LO);
	assign load_hi    = cpu.write && (page == `N163_PAGE_IRQ_HI);

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= 16'h0000;
			irq   <= 1'b0;
		end else if (cpu.ce) begin
			if (ack) begin
				irq <= 1'b0;
			end else if (count == 16'hFFFF) begin
				irq <= 1'b1;
			end

			// each byte loads independently, a load wins over the count
			if (load_lo) begin
				count[7:0] <= cpu.wdata;
			end else if (count_up) begin
				count[7:0] <= count_next[7:0];
			end

			if (load_hi) begin
				count[15:8] <= cpu.wdata;
			end else if (count_up) begin
				count[15:8] <= count_next[15:8];
			end
		end
	end

	assign irq_state.count = count;
	assign irq_state.irq   = irq;

endmodule

// ==== rtl/n163_mapper.sv ====
// n163 mapper top: bank registers and irq counter side by side, cpu port combines them
`timescale 1ns/1ns
`include "n163_cfg.svh"

module n163_mapper (
	input  logic                clk20,
	input  logic                reset,
	input  n163_pkg::cpu_bus_t  cpu,
	input  logic [13:0]         chr_addr,
	output logic [7:0]          prg_dout,
	output logic                prg_oe,
	output logic [21:0]         prg_aout,
	output logic                prg_allow,
	output logic [21:0]         chr_aout,
	output logic                vram_ce,
	output logic                vram_a10,
	output logic                irq
);

	n163_pkg::bank_map_t  map;
	n163_pkg::irq_state_t irq_state;

	n163_bank_regs u_bank (
		.clk20    (clk20),
		.reset    (reset),
		.cpu      (cpu),
		.chr_addr (chr_addr),
		.map      (map)
	);

	n163_irq_counter u_irq (
		.clk20     (clk20),
		.reset     (reset),
		.cpu       (cpu),
		.irq_state (irq_state)
	);

	n163_cpu_port u_port (
		.cpu       (cpu),
		.map       (map),
		.irq_state (irq_state),
		.prg_dout  (prg_dout),
		.prg_oe    (prg_oe),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	// chr side, 1k bank over the 10-bit in-page offset
	assign chr_aout = {`N163_CHR_BASE, map.chr_bank, chr_addr[9:0]};
	assign vram_ce  = map.ciram_ce;
	assign vram_a10 = map.vram_a10;
	assign irq      = irq_state.irq;

endmodule

// ==== rtl/n163_pkg.sv ====
// shared struct types for the n163 mapper: cpu bus, bank translation result, irq counter state
package n163_pkg;

	// strobed cpu bus, one clk20 cycle of ce per cpu cycle
	typedef struct packed {
		logic        ce;    // cpu cycle strobe
		logic        write; // high for a store
		logic [15:0] addr;
		logic [7:0]  wdata; // cpu data bus, also the open bus value on reads
	} cpu_bus_t;

	// result of the bank registers for the current cpu and ppu address
	typedef struct packed {
		logic [5:0] prg_bank; // prg address 18:13, masked
		logic [7:0] chr_bank; // chr address 17:10, masked
		logic       ciram_ce; // route to console vram instead of chr
		logic       vram_a10; // vram page select when ciram_ce is set
	} bank_map_t;

	// cycle counter and its interrupt flag
	typedef struct packed {
		logic [15:0] count; // bit 15 is the run enable
		logic        irq;
	} irq_state_t;

endpackage

// ==== testbench/n163_sva.sv ====
// concurrent checks on the n163 mapper top level that bind attaches to every n163_mapper
`timescale 1ns/1ns

module n163_sva (
	input logic               clk20,
	input logic               reset,
	input n163_pkg::cpu_bus_t cpu,
	input logic               irq
);

	int failures = 0;

	irq_clear_after_reset: assert property (@(posedge clk20) reset |=> !irq)
		else begin
			$error("irq high in the cycle after reset");
			failures++;
		end

	// any cpu cycle in $5000-$5fff is the acknowledge
	irq_ack: assert property (@(posedge clk20) disable iff (reset)
		cpu.ce && cpu.addr[15:12] == 4'h5 |=> !irq)
		else begin
			$error("irq still high after a cpu cycle in $5000-$5fff");
			failures++;
		end

	// irq only moves on the edge that ends a cpu cycle
	irq_on_cpu_cycle: assert property (@(posedge clk20) disable iff (reset)
		!$stable(irq) |-> $past(cpu.ce))
		else begin
			$error("irq changed on an edge without a cpu cycle");
			failures++;
		end

endmodule

bind n163_mapper n163_sva u_sva (
	.clk20(clk20), .reset(reset), .cpu(cpu), .irq(irq)
);

// ==== testbench/tb_checker.sv ====
// compares the n163 mapper outputs one clock after each table step against its expected values
`timescale 1ns/1ns

module tb_checker (
	input  logic        clk20,
	input  logic        reset,
	input  logic [7:0]  prg_dout,
	input  logic        prg_oe,
	input  logic [21:0] prg_aout,
	input  logic        prg_allow,
	input  logic [21:0] chr_aout,
	input  logic        vram_ce,
	input  logic        vram_a10,
	input  logic        irq,
	input  logic [7:0]  check, // from bit 0: dout, aout, oe, allow, chr, vram_ce, vram_a10, irq
	input  logic [7:0]  exp_dout,
	input  logic [21:0] exp_aout,
	input  logic        exp_oe,
	input  logic        exp_allow,
	input  logic [21:0] exp_chr,
	input  logic        exp_vram_ce,
	input  logic        exp_vram_a10,
	input  logic        exp_irq,
	output int          mismatches,
	output int          checks
);

	task automatic compare(input string what, input logic [21:0] got, input logic [21:0] want);
		checks++;
		if (got !== want) begin
			mismatches++;
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	initial begin
		mismatches = 0;
		checks     = 0;
	end

	// step and outputs were set up during the cycle that ends here
	always @(posedge clk20) begin
		if (!reset) begin
			if (check[0]) compare("prg_dout", prg_dout, exp_dout);
			if (check[1]) compare("prg_aout", prg_aout, exp_aout);
			if (check[2]) compare("prg_oe", prg_oe, exp_oe);
			if (check[3]) compare("prg_allow", prg_allow, exp_allow);
			if (check[4]) compare("chr_aout", chr_aout, exp_chr);
			if (check[5]) compare("vram_ce", vram_ce, exp_vram_ce);
			if (check[6]) compare("vram_a10", vram_a10, exp_vram_a10);
			if (check[7]) compare("irq", irq, exp_irq);
		end
	end

endmodule

// ==== testbench/tb_clock.sv ====
// free-running 4 ns clk20 and a synchronous active-high reset for the first three rising edges
`timescale 1ns/1ns

module tb_clock (
	output logic clk20,
	output logic reset
);

	initial begin
		clk20 = 1'b0;
		forever begin
			#2 clk20 = ~clk20;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk20);
		reset <= 1'b0; // seen high on three edges
	end

endmodule

// ==== testbench/tb_n163.sv ====
// testbench top for the n163 mapper that applies a table of steps and reports the result
`timescale 1ns/1ns
`include "n163_cfg.svh"

module tb_n163;

	typedef struct packed {
		n163_pkg::cpu_bus_t cpu;
		logic [13:0]        chr_addr;
		logic [7:0]         check;    // chk_* bits of the fields compared
		logic [7:0]         dout;
		logic [21:0]        aout;
		logic               oe;
		logic               allow;
		logic [21:0]        chr;
		logic               vram_ce;
		logic               vram_a10;
		logic               irq;
		logic               wait_irq; // repeat this cpu cycle until irq
	} step_t;

	// bit order matches the check port of tb_checker
	localparam logic [7:0] chk_dout  = 8'h01;
	localparam logic [7:0] chk_aout  = 8'h02;
	localparam logic [7:0] chk_oe    = 8'h04;
	localparam logic [7:0] chk_allow = 8'h08;
	localparam logic [7:0] chk_chr   = 8'h10;
	localparam logic [7:0] chk_vce   = 8'h20;
	localparam logic [7:0] chk_a10   = 8'h40;
	localparam logic [7:0] chk_irq   = 8'h80;
	localparam int irq_timeout   = 64;
	localparam int reset_timeout = 16;

	logic        clk20;
	logic        reset;
	step_t       cur;      // step on the DUT inputs this cycle
	step_t       steps[$];
	logic [7:0]  prg_dout;
	logic        prg_oe;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic [21:0] chr_aout;
	logic        vram_ce;
	logic        vram_a10;
	logic        irq;
	int          mismatches;
	int          checks;
	int          timeouts;

	tb_clock u_clock (.clk20(clk20), .reset(reset));

	n163_mapper u_dut (
		.clk20(clk20), .reset(reset), .cpu(cur.cpu), .chr_addr(cur.chr_addr),
		.prg_dout(prg_dout), .prg_oe(prg_oe), .prg_aout(prg_aout), .prg_allow(prg_allow),
		.chr_aout(chr_aout), .vram_ce(vram_ce), .vram_a10(vram_a10), .irq(irq)
	);

	tb_checker u_check (
		.clk20(clk20), .reset(reset),
		.prg_dout(prg_dout), .prg_oe(prg_oe), .prg_aout(prg_aout), .prg_allow(prg_allow),
		.chr_aout(chr_aout), .vram_ce(vram_ce), .vram_a10(vram_a10), .irq(irq),
		.check(cur.check), .exp_dout(cur.dout), .exp_aout(cur.aout), .exp_oe(cur.oe),
		.exp_allow(cur.allow), .exp_chr(cur.chr), .exp_vram_ce(cur.vram_ce),
		.exp_vram_a10(cur.vram_a10), .exp_irq(cur.irq),
		.mismatches(mismatches), .checks(checks)
	);

	function automatic step_t cpu_step(input logic ce, input logic wr, input logic [15:0] addr,
		input logic [7:0] data);
		step_t s;
		s     = '0;
		s.cpu = '{ce: ce, write: wr, addr: addr, wdata: data};
		return s;
	endfunction

	// rom read address is the masked bank over the 8k offset
	function automatic logic [21:0] rom_addr(input logic [5:0] bank, input logic [15:0] addr);
		return {3'b000, bank & `N163_PRG_MASK, addr[12:0]};
	endfunction

	task automatic queue_write(input logic [15:0] addr, input logic [7:0] data);
		steps.push_back(cpu_step(1'b1, 1'b1, addr, data));
	endtask

	task automatic prg_access(input logic wr, input logic [15:0] addr, input logic [21:0] aout);
		step_t s;
		s       = cpu_step(1'b1, wr, addr, 8'h00);
		s.check = chk_aout | chk_oe | chk_allow;
		s.aout  = aout;
		s.oe    = !wr;
		s.allow = 1'b1;
		steps.push_back(s);
	endtask

	// open bus value on the data lines differs from every expected register byte
	task automatic reg_read(input logic [15:0] addr, input logic [7:0] dout, input logic irq_now);
		step_t s;
		s       = cpu_step(1'b1, 1'b0, addr, 8'hA5);
		s.check = chk_dout | chk_oe | chk_irq;
		s.dout  = dout;
		s.oe    = 1'b1;
		s.irq   = irq_now;
		steps.push_back(s);
	endtask

	// ppu address moves without a cpu cycle
	task automatic ppu_step(input logic [13:0] chr_addr, input logic [7:0] check,
		input logic [21:0] chr, input logic vce, input logic a10, input logic irq_now);
		step_t s;
		s          = cpu_step(1'b0, 1'b0, 16'h0000, 8'h00);
		s.chr_addr = chr_addr;
		s.check    = check;
		s.chr      = chr;
		s.vram_ce  = vce;
		s.vram_a10 = a10;
		s.irq      = irq_now;
		steps.push_back(s);
	endtask

	task automatic build_table();
		step_t s;
		queue_write(16'hE000, 8'h05);
		queue_write(16'hE800, 8'h07);
		queue_write(16'hF000, 8'h09);
		prg_access(1'b0, 16'h8123, rom_addr(6'd5, 16'h8123));
		prg_access(1'b0, 16'hA456, rom_addr(6'd7, 16'hA456));
		prg_access(1'b0, 16'hC789, rom_addr(6'd9, 16'hC789));
		prg_access(1'b0, 16'hE0AB, rom_addr(6'd63, 16'hE0AB)); // last window fixed
		prg_access(1'b0, 16'h6123, {`N163_WRAM_BANK, 13'h0123});
		prg_access(1'b1, 16'h6123, {`N163_WRAM_BANK, 13'h0123});
		reg_read(16'h4823, 8'h00, 1'b0); // sound port reads zero
		queue_write(16'h8800, 8'h12);
		ppu_step(14'h0456, chk_chr | chk_vce, {`N163_CHR_BASE, 8'h12, 10'h056}, 1'b0, 1'b0, 1'b0);
		queue_write(16'hC000, 8'hE1);
		ppu_step(14'h2000, chk_vce | chk_a10, 22'h0, 1'b1, 1'b1, 1'b0);
		queue_write(16'h5000, 8'h34);
		queue_write(16'h5800, 8'h12);
		reg_read(16'h5000, 8'h34, 1'b0);
		reg_read(16'h5800, 8'h12, 1'b0);
		reg_read(16'h5000, 8'h34, 1'b0); // bit 15 clear so no count
		queue_write(16'h5000, 8'hFE);
		queue_write(16'h5800, 8'hFF);
		s          = cpu_step(1'b1, 1'b0, 16'h8000, 8'h00);
		s.wait_irq = 1'b1;
		steps.push_back(s);
		reg_read(16'h5800, 8'hFF, 1'b1);
		ppu_step(14'h0000, chk_irq, 22'h0, 1'b0, 1'b0, 1'b0); // acked by the read
	endtask

	task automatic drive(input step_t s);
		@(posedge clk20);
		cur <= s;
	endtask

	task automatic release_wait();
		int waited;
		waited = 0;
		@(negedge clk20);
		while (reset !== 1'b0 && waited < reset_timeout) begin
			@(negedge clk20);
			waited++;
		end
		if (reset !== 1'b0) begin
			$display("reset still high after %0d cycles", reset_timeout);
			timeouts++;
		end
	endtask

	task automatic run_until_irq(input step_t s);
		int waited;
		waited = 0;
		drive(s);
		@(negedge clk20);
		while (irq !== 1'b1 && waited < irq_timeout) begin
			drive(s);
			@(negedge clk20);
			waited++;
		end
		if (irq !== 1'b1) begin
			$display("irq never arrived within %0d cpu cycles of saturation", irq_timeout);
			timeouts++;
		end
	endtask

	initial begin
		int total;
		cur      = '0; // DUT inputs idle until the first drive
		timeouts = 0;
		build_table();
		release_wait();
		foreach (steps[i]) begin
			if (steps[i].wait_irq) begin
				run_until_irq(steps[i]);
			end else begin
				drive(steps[i]);
			end
			if (steps[i].cpu.ce && steps[i].cpu.write) begin
				drive(cpu_step(1'b0, 1'b0, 16'h0000, 8'h00)); // write lands before the next step
			end
		end
		drive(cpu_step(1'b0, 1'b0, 16'h0000, 8'h00)); // edge that samples the last step
		@(negedge clk20);
		total = mismatches + timeouts + u_dut.u_sva.failures;
		$display("steps %0d, checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			steps.size(), checks, mismatches, timeouts, u_dut.u_sva.failures);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
